/* logic/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    // field widths of one 32-bit instruction word
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;
    localparam int NUM_REGS = 2 ** REG_W;

    // primary opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // funct codes under OP_SPECIAL
    typedef enum logic [FUNCT_W-1:0] {
        FN_JR   = 6'b001000,
        FN_MFLO = 6'b010010,
        FN_MTLO = 6'b010011
    } funct_e;

    // low half of an r-type word
    typedef struct packed {
        logic [REG_W-1:0]   rd;
        logic [SHAMT_W-1:0] shamt;
        funct_e             funct;
    } rfields_t;

    // low 16 bits read either as r-type fields or as the i-type immediate
    typedef union packed {
        rfields_t         r;
        logic [IMM_W-1:0] imm;
    } low_t;

    typedef struct packed {
        opcode_e          opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        low_t             low;
    } instr_t;

endpackage

`default_nettype wire

/* logic/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    import mips_isa_pkg::*;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // first fetch address after start
    localparam logic [ADDR_W-1:0] RESET_VECTOR = 32'hBFC0_0000;

    // instruction and data memory sizes in words
    localparam int IMEM_WORDS = 4096;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS = 1024;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // fetch to execute record
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        instr_t            instr;
    } fetch_entry_t;

    // execute to store port record, byte address
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } store_entry_t;

endpackage

`default_nettype wire

/* logic/queue_if.sv */
`default_nettype none

interface queue_if #(
    parameter type entry_t = logic [31:0]
);

    // push side, one-cycle strobe with a valid entry
    logic   push;
    entry_t push_data;

    // pop side, head entry valid while empty is low
    logic   pop;
    entry_t pop_data;

    logic   empty;
    // only observed by assertions, no back-pressure
    logic   full;

    modport producer (output push, output push_data, input full);
    modport queue    (input push, input push_data, input pop,
                      output pop_data, output empty, output full);
    modport consumer (output pop, input pop_data, input empty);

endinterface

`default_nettype wire

/* logic/instr_rom.sv */
`default_nettype none

module instr_rom
    import mips_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic [ADDR_W-1:0] addr,
    output instr_t            instr
);

    instr_t mem [IMEM_WORDS];

    // byte offset from the reset vector
    logic [ADDR_W-1:0] rom_off;

    // self-check program, built once at elaboration
    initial begin
        int     w;
        instr_t ins;

        w = 0;
        // unused words hold zero
        for (int k = 0; k < IMEM_WORDS; k++) begin
            mem[k] = '0;
        end

        // lw rN, 4*(N-2)(r0) for r2..r16
        for (int n = 2; n <= 16; n++) begin
            ins         = '0;
            ins.opcode  = OP_LW;
            ins.rt      = REG_W'(n);
            ins.low.imm = IMM_W'((n - 2) * 4);
            mem[w]      = ins;
            w++;
        end

        // mtlo rN then mflo r(N+15), copies r2..r15 into r17..r30
        for (int n = 2; n <= 15; n++) begin
            ins              = '0;
            ins.opcode       = OP_SPECIAL;
            ins.rs           = REG_W'(n);
            ins.low.r.funct  = FN_MTLO;
            mem[w]           = ins;
            w++;
            ins              = '0;
            ins.opcode       = OP_SPECIAL;
            ins.low.r.rd     = REG_W'(n + 15);
            ins.low.r.funct  = FN_MFLO;
            mem[w]           = ins;
            w++;
        end

        // sw rN, 0x400 + 4*(N-17)(r0) for r17..r30
        for (int n = 17; n <= 30; n++) begin
            ins         = '0;
            ins.opcode  = OP_SW;
            ins.rt      = REG_W'(n);
            ins.low.imm = IMM_W'(16'h400 + (n - 17) * 4);
            mem[w]      = ins;
            w++;
        end

        // jr r0 halts once the delay slot has gone
        ins             = '0;
        ins.opcode      = OP_SPECIAL;
        ins.low.r.funct = FN_JR;
        mem[w]          = ins;
        w++;

        // delay slot, addiu r2, r0, 0
        ins        = '0;
        ins.opcode = OP_ADDIU;
        ins.rt     = REG_W'(2);
        mem[w]     = ins;
    end

    assign rom_off = addr % RESET_VECTOR;
    // word index, upper bits wrap
    assign instr   = mem[rom_off[IMEM_AW+1:2]];

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`default_nettype none

module fetch_unit
    import mips_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic [ADDR_W-1:0] rom_addr,
    input  instr_t            rom_instr,
    queue_if.producer         fq_push,
    output logic              stopped
);

    logic [ADDR_W-1:0] pc;
    logic              running;
    // set once jr r0 has been pushed so the next push is the delay slot
    logic              in_slot;
    logic              is_halt;
    fetch_entry_t      entry;

    // jr r0 is the only branch and is decoded only here
    assign is_halt = (rom_instr.opcode == OP_SPECIAL)
                  && (rom_instr.low.r.funct == FN_JR)
                  && (rom_instr.rs == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            in_slot <= 1'b0;
            pc      <= RESET_VECTOR;
        end else if (start) begin
            running <= 1'b1;
            in_slot <= 1'b0;
            pc      <= RESET_VECTOR;
        end else if (running) begin
            pc <= pc + 32'd4;
            // delay slot pushed this cycle so stop
            if (in_slot) begin
                running <= 1'b0;
                in_slot <= 1'b0;
            end else if (is_halt) begin
                in_slot <= 1'b1;
            end
        end
    end

    assign rom_addr    = pc;
    assign entry.pc    = pc;
    assign entry.instr = rom_instr;

    // one push per running cycle
    assign fq_push.push      = running;
    assign fq_push.push_data = entry;
    assign stopped           = !running;

    // no stall path so the queue must always take the entry
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        fq_push.push |-> !fq_push.full);

endmodule

`default_nettype wire

/* logic/sync_queue.sv */
`default_nettype none

module sync_queue #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 4
) (
    input logic    clk,
    input logic    rst,
    queue_if.queue q
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // push into a full queue is only taken when a pop frees a slot
    assign do_push = q.push && (!q.full || q.pop);
    assign do_pop  = q.pop && !q.empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q.push_data;
        end
    end

    assign q.pop_data = mem[rd_ptr];
    assign q.empty    = (count == '0);
    assign q.full     = (count == CNT_W'(DEPTH));

    // producer must drain as fast as it fills
    a_overflow: assert property (@(posedge clk) disable iff (rst)
        !(q.push && q.full && !q.pop));

    // consumer pops only a valid head
    a_underflow: assert property (@(posedge clk) disable iff (rst)
        !(q.pop && q.empty));

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`default_nettype none

module exec_unit
    import mips_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    queue_if.consumer          fq_pop,
    queue_if.producer          sq_push,
    input  logic               dmem_load,
    input  logic [DMEM_AW-1:0] dmem_load_addr,
    input  logic [DATA_W-1:0]  dmem_load_data,
    output logic               busy
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic [DATA_W-1:0] lo;
    // word addressed data memory
    logic [DATA_W-1:0] dmem [DMEM_WORDS];

    fetch_entry_t       cur;
    instr_t             ins;
    logic               exec;
    logic [DATA_W-1:0]  rs_val;
    logic [DATA_W-1:0]  rt_val;
    logic [DATA_W-1:0]  imm_sext;
    logic [ADDR_W-1:0]  ea;
    logic [DMEM_AW-1:0] ea_word;
    logic               is_lw;
    logic               is_sw;
    logic               is_addiu;
    logic               is_mtlo;
    logic               is_mflo;
    logic               wr_en;
    logic [REG_W-1:0]   wr_reg;
    logic [DATA_W-1:0]  wr_val;
    store_entry_t       st;

    // take the head whenever one is there, whole instruction done this cycle
    assign exec   = !fq_pop.empty;
    assign fq_pop.pop = exec;
    assign cur    = fq_pop.pop_data;
    assign ins    = cur.instr;
    assign busy   = exec;

    // decode
    assign is_lw    = (ins.opcode == OP_LW);
    assign is_sw    = (ins.opcode == OP_SW);
    assign is_addiu = (ins.opcode == OP_ADDIU);
    assign is_mtlo  = (ins.opcode == OP_SPECIAL) && (ins.low.r.funct == FN_MTLO);
    assign is_mflo  = (ins.opcode == OP_SPECIAL) && (ins.low.r.funct == FN_MFLO);
    // jr falls through every case, fetch already acted on it

    // r0 reads as zero
    assign rs_val   = (ins.rs == '0) ? '0 : regs[ins.rs];
    assign rt_val   = (ins.rt == '0) ? '0 : regs[ins.rt];
    assign imm_sext = {{(DATA_W - IMM_W){ins.low.imm[IMM_W-1]}}, ins.low.imm};
    assign ea       = rs_val + imm_sext;
    assign ea_word  = ea[DMEM_AW+1:2];

    // register write port
    always_comb begin
        wr_reg = ins.rt;
        wr_val = rs_val + imm_sext;
        if (is_lw) begin
            wr_val = dmem[ea_word];
        end else if (is_mflo) begin
            wr_reg = ins.low.r.rd;
            wr_val = lo;
        end
    end
    assign wr_en = exec && (is_lw || is_addiu || is_mflo) && (wr_reg != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_reg] <= wr_val;
        end
        if (exec && is_mtlo) begin
            lo <= rs_val;
        end
    end

    // preload has the port while idle, stores otherwise
    always_ff @(posedge clk) begin
        if (dmem_load) begin
            dmem[dmem_load_addr] <= dmem_load_data;
        end else if (exec && is_sw) begin
            dmem[ea_word] <= rt_val;
        end
    end

    // store record leaves in the same cycle
    assign st.addr           = ea;
    assign st.data           = rt_val;
    assign sq_push.push      = exec && is_sw;
    assign sq_push.push_data = st;

    // back-to-back instructions come from consecutive fetch addresses
    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        exec ##1 exec |-> cur.pc == $past(cur.pc) + 32'd4);

endmodule

`default_nettype wire

/* logic/mtlo_core.sv */
`default_nettype none

module mtlo_core
    import mips_isa_pkg::*;
    import core_cfg_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               dmem_load,
    input  logic [DMEM_AW-1:0] dmem_load_addr,
    input  logic [DATA_W-1:0]  dmem_load_data,
    output logic               store_valid,
    output logic [ADDR_W-1:0]  store_addr,
    output logic [DATA_W-1:0]  store_data,
    output logic               done
);

    logic [ADDR_W-1:0] rom_addr;
    instr_t            rom_instr;
    logic              stopped;
    logic              busy;
    // a run has been started since reset
    logic              run_seen;

    queue_if #(.entry_t(fetch_entry_t)) fq ();
    queue_if #(.entry_t(store_entry_t)) sq ();

    instr_rom rom_i (
        .addr  (rom_addr),
        .instr (rom_instr)
    );

    fetch_unit fetch_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .rom_addr  (rom_addr),
        .rom_instr (rom_instr),
        .fq_push   (fq.producer),
        .stopped   (stopped)
    );

    sync_queue #(.entry_t(fetch_entry_t), .DEPTH(DEPTH)) fq_i (
        .clk (clk),
        .rst (rst),
        .q   (fq.queue)
    );

    exec_unit exec_i (
        .clk            (clk),
        .rst            (rst),
        .fq_pop         (fq.consumer),
        .sq_push        (sq.producer),
        .dmem_load      (dmem_load),
        .dmem_load_addr (dmem_load_addr),
        .dmem_load_data (dmem_load_data),
        .busy           (busy)
    );

    sync_queue #(.entry_t(store_entry_t), .DEPTH(DEPTH)) sq_i (
        .clk (clk),
        .rst (rst),
        .q   (sq.queue)
    );

    // drain the store queue onto the port, one record per cycle
    assign sq.pop      = !sq.empty;
    assign store_valid = !sq.empty;
    assign store_addr  = sq.pop_data.addr;
    assign store_data  = sq.pop_data.data;

    // done holds from drain until the next start
    always_ff @(posedge clk) begin
        if (rst) begin
            run_seen <= 1'b0;
            done     <= 1'b0;
        end else if (start) begin
            run_seen <= 1'b1;
            done     <= 1'b0;
        end else if (run_seen && stopped && fq.empty && sq.empty && !busy) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* test/tb_mtlo_core.sv */
`default_nettype none

module tb_mtlo_core
    import core_cfg_pkg::*;
();

    localparam int NUM_RUNS     = 2;
    localparam int NUM_WORDS    = 15;
    localparam int NUM_STORES   = 14;
    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CYCLES = 20;
    localparam int DONE_TIMEOUT = 400;
    localparam logic [ADDR_W-1:0] STORE_BASE = 32'h0000_0400;

    logic               clk;
    logic               rst;
    logic               start;
    logic               dmem_load;
    logic [DMEM_AW-1:0] dmem_load_addr;
    logic [DATA_W-1:0]  dmem_load_data;
    logic               store_valid;
    logic [ADDR_W-1:0]  store_addr;
    logic [DATA_W-1:0]  store_data;
    logic               done;

    // preload words per run and the store stream they should produce
    logic [DATA_W-1:0] preload_tab [NUM_RUNS][NUM_WORDS];
    logic [ADDR_W-1:0] exp_addr_tab [NUM_STORES];
    logic [DATA_W-1:0] exp_data_tab [NUM_RUNS][NUM_STORES];

    // store records seen on the port during one run
    logic [ADDR_W-1:0] got_addr [$];
    logic [DATA_W-1:0] got_data [$];

    integer seed;
    int     mismatch_count;
    int     failure_count;

    mtlo_core #(.DEPTH(4)) dut_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .dmem_load      (dmem_load),
        .dmem_load_addr (dmem_load_addr),
        .dmem_load_data (dmem_load_data),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .done           (done)
    );

    always #4 clk = ~clk;

    // one step past the rising edge, inputs change and outputs are settled here
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // random words with a few fixed corner values
    task automatic build_tables();
        seed = 92669;
        for (int r = 0; r < NUM_RUNS; r++) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                preload_tab[r][k] = $random(seed);
            end
        end
        preload_tab[0][3]  = '0;
        preload_tab[0][10] = '1;
        preload_tab[1][6]  = '1;
        preload_tab[1][13] = '0;
        // stored word k lands at 0x400 + 4k and equals preload word k
        for (int k = 0; k < NUM_STORES; k++) begin
            exp_addr_tab[k] = STORE_BASE + ADDR_W'(4 * k);
            for (int r = 0; r < NUM_RUNS; r++) begin
                exp_data_tab[r][k] = preload_tab[r][k];
            end
        end
    endtask

    // word k goes to data word k while the core is idle
    task automatic preload_dmem(input int run);
        for (int k = 0; k < NUM_WORDS; k++) begin
            dmem_load      = 1'b1;
            dmem_load_addr = DMEM_AW'(k);
            dmem_load_data = preload_tab[run][k];
            next_cycle();
        end
        dmem_load      = 1'b0;
        dmem_load_addr = '0;
        dmem_load_data = '0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    // nothing may come out before a start
    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            assert (store_valid === 1'b0) else begin
                $display("mismatch at %0t: store_valid high before start", $time);
                mismatch_count++;
            end
            assert (done === 1'b0) else begin
                $display("mismatch at %0t: done high before start", $time);
                mismatch_count++;
            end
        end
    endtask

    // record every strobe until done, bounded by DONE_TIMEOUT
    task automatic collect_run();
        int cycles;

        cycles = 0;
        got_addr.delete();
        got_data.delete();
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            next_cycle();
            if (store_valid === 1'b1) begin
                got_addr.push_back(store_addr);
                got_data.push_back(store_data);
            end
            cycles++;
        end
        assert (done === 1'b1) else begin
            $display("timeout: done did not rise within %0d cycles after start",
                     DONE_TIMEOUT);
            failure_count++;
        end
    endtask

    task automatic check_stores(input int run);
        int n;

        assert (got_addr.size() == NUM_STORES) else begin
            $display("mismatch at %0t: run %0d gave %0d stores, expected %0d",
                     $time, run, got_addr.size(), NUM_STORES);
            mismatch_count++;
        end
        n = (got_addr.size() < NUM_STORES) ? got_addr.size() : NUM_STORES;
        for (int k = 0; k < n; k++) begin
            assert (got_addr[k] === exp_addr_tab[k]) else begin
                $display("mismatch at %0t: run %0d store %0d addr %h, expected %h",
                         $time, run, k, got_addr[k], exp_addr_tab[k]);
                mismatch_count++;
            end
            assert (got_data[k] === exp_data_tab[run][k]) else begin
                $display("mismatch at %0t: run %0d store %0d data %h, expected %h",
                         $time, run, k, got_data[k], exp_data_tab[run][k]);
                mismatch_count++;
            end
        end
    endtask

    // halt after the delay slot, done holds and no late store
    task automatic check_halt();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            next_cycle();
            assert (done === 1'b1) else begin
                $display("mismatch at %0t: done dropped after the run", $time);
                mismatch_count++;
            end
            assert (store_valid === 1'b0) else begin
                $display("mismatch at %0t: store after halt, addr %h", $time, store_addr);
                mismatch_count++;
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        dmem_load      = 1'b0;
        dmem_load_addr = '0;
        dmem_load_data = '0;
        mismatch_count = 0;
        failure_count  = 0;
        build_tables();

        for (int i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
        end
        rst = 1'b0;

        check_idle(QUIET_CYCLES);

        // second run reloads memory and restarts from the reset vector
        for (int run = 0; run < NUM_RUNS; run++) begin
            preload_dmem(run);
            pulse_start();
            collect_run();
            check_stores(run);
            check_halt();
        end

        $display("errors: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
logic/mips_isa_pkg.sv
logic/core_cfg_pkg.sv
logic/queue_if.sv
logic/instr_rom.sv
logic/fetch_unit.sv
logic/sync_queue.sv
logic/exec_unit.sv
logic/mtlo_core.sv
test/tb_mtlo_core.sv

/* run.sh */
#!/bin/sh
# build and run the mtlo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if [ $? -ne 0 ]; then
    echo "could not clean obj_dir"
    exit 1
fi

verilator --binary --timing --assert -f project.f \
    --top-module tb_mtlo_core -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see sim.log"
    exit 1
fi

if grep -q "Test passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
